//--- include/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Queue slots
`define ISSUE_DEPTH 8

// Physical register index width for 64 registers
`define PREG_BITS 6

// ROB index width; the robid carries one extra wrap bit
`define ROB_BITS 5

`define PC_BITS 32

`endif

//--- source/issue_pkg.sv
`include "issue_settings.svh"

package issue_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // Micro-op as stored in a slot and sent to issue
    typedef struct packed {
        logic [`PC_BITS-1:0]   pc;
        logic [63:0]           imm;
        alu_op_t               alu_op;
        logic                  src1_is_reg;
        logic                  src2_is_reg;
        logic [`PREG_BITS-1:0] prs1;
        logic [`PREG_BITS-1:0] prs2;
        logic [`PREG_BITS-1:0] prd;
        logic [`ROB_BITS:0]    robid;
    } issue_uop_t;

endpackage

//--- source/issue_dispatch_if.sv
`timescale 1ns/1ps

`include "issue_settings.svh"

interface issue_dispatch_if;
    logic [`ISSUE_DEPTH-1:0] write_slot;
    issue_pkg::issue_uop_t   uop;
    logic                    src1_pending;
    logic                    src2_pending;

    modport ctrl (
        output write_slot,
        output uop,
        output src1_pending,
        output src2_pending
    );

    modport slot (
        input write_slot,
        input uop,
        input src1_pending,
        input src2_pending
    );
endinterface

//--- source/issue_queue_entry.sv
`timescale 1ns/1ps

module issue_queue_entry #(
    parameter int SLOT = 0
) (
    input  logic                  clock,
    input  logic                  reset_n,
    issue_dispatch_if.slot        dispatch,
    input  logic                  wakeup_src1,
    input  logic                  wakeup_src2,
    input  logic                  issuing,
    input  logic                  flush,
    output logic                  valid,
    output logic                  ready_to_go,
    output issue_pkg::issue_uop_t uop
);
    logic write;
    logic src1_pending;
    logic src2_pending;

    assign write = dispatch.write_slot[SLOT];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (write) begin
            valid <= 1'b1;
        end else if (issuing) begin
            valid <= 1'b0;
        end
    end

    // Enqueue wins over a wakeup in the same cycle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            src1_pending <= 1'b0;
        end else if (write) begin
            src1_pending <= dispatch.src1_pending;
        end else if (wakeup_src1) begin
            src1_pending <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            src2_pending <= 1'b0;
        end else if (write) begin
            src2_pending <= dispatch.src2_pending;
        end else if (wakeup_src2) begin
            src2_pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            uop <= dispatch.uop;
        end
    end

    assign ready_to_go = valid & ~src1_pending & ~src2_pending;

    // Allocation must only pick empty slots
    a_no_overwrite: assert property (
        @(posedge clock) disable iff (!reset_n) write |-> !valid
    );
endmodule

//--- source/issue_wakeup.sv
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_wakeup (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    flush,
    input  logic                    writeback_valid,
    input  logic [`PREG_BITS-1:0]   writeback_preg,
    input  issue_pkg::issue_uop_t   dispatch_uop,
    input  logic                    dispatch_fire,
    input  logic [`PREG_BITS-1:0]   slot_prs1 [`ISSUE_DEPTH],
    input  logic [`PREG_BITS-1:0]   slot_prs2 [`ISSUE_DEPTH],
    input  logic [`ISSUE_DEPTH-1:0] slot_valid,
    output logic                    src1_pending,
    output logic                    src2_pending,
    output logic [`ISSUE_DEPTH-1:0] wakeup_src1,
    output logic [`ISSUE_DEPTH-1:0] wakeup_src2
);
    localparam int PREGS = 1 << `PREG_BITS;

    logic [PREGS-1:0] busy;
    logic             wb_hit1;
    logic             wb_hit2;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (writeback_valid) begin
                busy[writeback_preg] <= 1'b0;
            end
            // x0 is hardwired and never waits
            if (dispatch_fire && dispatch_uop.prd != '0) begin
                busy[dispatch_uop.prd] <= 1'b1;
            end
        end
    end

    // Bypass a writeback that lands in the dispatch cycle
    assign wb_hit1 = writeback_valid && (writeback_preg == dispatch_uop.prs1);
    assign wb_hit2 = writeback_valid && (writeback_preg == dispatch_uop.prs2);

    assign src1_pending = dispatch_uop.src1_is_reg && busy[dispatch_uop.prs1] && !wb_hit1;
    assign src2_pending = dispatch_uop.src2_is_reg && busy[dispatch_uop.prs2] && !wb_hit2;

    always_comb begin
        for (int i = 0; i < `ISSUE_DEPTH; i++) begin
            wakeup_src1[i] = writeback_valid && slot_valid[i]
                             && (slot_prs1[i] == writeback_preg);
            wakeup_src2[i] = writeback_valid && slot_valid[i]
                             && (slot_prs2[i] == writeback_preg);
        end
    end

    // A destination in flight must not be claimed again by dispatch
    a_prd_free: assert property (
        @(posedge clock) disable iff (!reset_n || flush)
        dispatch_fire && dispatch_uop.prd != '0 |-> !busy[dispatch_uop.prd]
    );
endmodule

//--- source/issue_dispatch_ctrl.sv
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_dispatch_ctrl (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    dispatch_req,
    output logic                    dispatch_ack,
    input  issue_pkg::issue_uop_t   dispatch_uop,
    input  logic [`ISSUE_DEPTH-1:0] slot_valid,
    input  logic                    src1_pending,
    input  logic                    src2_pending,
    output logic                    dispatch_fire,
    issue_dispatch_if.ctrl          dispatch
);
    logic [`ISSUE_DEPTH-1:0] free_slots;
    logic [`ISSUE_DEPTH-1:0] alloc_slot;

    assign free_slots = ~slot_valid;

    // Lowest set bit of the free vector
    assign alloc_slot = free_slots & (~free_slots + 1'b1);

    // Accept once per request, only while ack is still low
    assign dispatch_fire = dispatch_req && !dispatch_ack && (|free_slots);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dispatch_ack <= 1'b0;
        end else if (dispatch_fire) begin
            dispatch_ack <= 1'b1;
        end else if (!dispatch_req) begin
            dispatch_ack <= 1'b0;
        end
    end

    assign dispatch.write_slot   = dispatch_fire ? alloc_slot : '0;
    assign dispatch.uop          = dispatch_uop;
    assign dispatch.src1_pending = src1_pending;
    assign dispatch.src2_pending = src2_pending;

    a_ack_after_req: assert property (
        @(posedge clock) disable iff (!reset_n)
        $rose(dispatch_ack) |-> $past(dispatch_req)
    );

    a_write_onehot: assert property (
        @(posedge clock) disable iff (!reset_n)
        dispatch_fire |-> $onehot(dispatch.write_slot)
    );
endmodule

//--- source/issue_select.sv
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_select (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic [`ISSUE_DEPTH-1:0] slot_ready,
    input  issue_pkg::issue_uop_t   slot_uop [`ISSUE_DEPTH],
    input  logic                    issue_ready,
    output logic                    issue_valid,
    output issue_pkg::issue_uop_t   issue_uop,
    output logic [`ISSUE_DEPTH-1:0] issuing
);
    localparam int IDX_BITS = (`ISSUE_DEPTH > 1) ? $clog2(`ISSUE_DEPTH) : 1;

    logic [IDX_BITS-1:0] grant_idx;

    // Lowest ready index wins, so scan downwards
    always_comb begin
        grant_idx = '0;
        for (int i = `ISSUE_DEPTH - 1; i >= 0; i--) begin
            if (slot_ready[i]) begin
                grant_idx = IDX_BITS'(i);
            end
        end
    end

    assign issue_valid = |slot_ready;
    assign issue_uop   = slot_uop[grant_idx];

    always_comb begin
        issuing = '0;
        if (issue_valid && issue_ready) begin
            issuing[grant_idx] = 1'b1;
        end
    end

    a_issue_onehot: assert property (
        @(posedge clock) disable iff (!reset_n)
        $onehot0(issuing)
    );
endmodule

//--- source/issue_queue.sv
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_queue (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  flush,
    input  logic                  dispatch_req,
    output logic                  dispatch_ack,
    input  logic [`PC_BITS-1:0]   dispatch_pc,
    input  logic [63:0]           dispatch_imm,
    input  issue_pkg::alu_op_t    dispatch_alu_op,
    input  logic                  dispatch_src1_is_reg,
    input  logic                  dispatch_src2_is_reg,
    input  logic [`PREG_BITS-1:0] dispatch_prs1,
    input  logic [`PREG_BITS-1:0] dispatch_prs2,
    input  logic [`PREG_BITS-1:0] dispatch_prd,
    input  logic [`ROB_BITS:0]    dispatch_robid,
    input  logic                  writeback_valid,
    input  logic [`PREG_BITS-1:0] writeback_preg,
    input  logic                  issue_ready,
    output logic                  issue_valid,
    output logic [`PC_BITS-1:0]   issue_pc,
    output logic [63:0]           issue_imm,
    output issue_pkg::alu_op_t    issue_alu_op,
    output logic [`PREG_BITS-1:0] issue_prs1,
    output logic [`PREG_BITS-1:0] issue_prs2,
    output logic [`PREG_BITS-1:0] issue_prd,
    output logic [`ROB_BITS:0]    issue_robid
);
    issue_pkg::issue_uop_t   dispatch_uop;
    issue_pkg::issue_uop_t   issue_uop;
    issue_pkg::issue_uop_t   slot_uop [`ISSUE_DEPTH];
    logic [`PREG_BITS-1:0]   slot_prs1 [`ISSUE_DEPTH];
    logic [`PREG_BITS-1:0]   slot_prs2 [`ISSUE_DEPTH];
    logic [`ISSUE_DEPTH-1:0] slot_valid;
    logic [`ISSUE_DEPTH-1:0] slot_ready;
    logic [`ISSUE_DEPTH-1:0] wakeup_src1;
    logic [`ISSUE_DEPTH-1:0] wakeup_src2;
    logic [`ISSUE_DEPTH-1:0] issuing;
    logic                    src1_pending;
    logic                    src2_pending;
    logic                    dispatch_fire;

    issue_dispatch_if dispatch_bus ();

    assign dispatch_uop.pc          = dispatch_pc;
    assign dispatch_uop.imm         = dispatch_imm;
    assign dispatch_uop.alu_op      = dispatch_alu_op;
    assign dispatch_uop.src1_is_reg = dispatch_src1_is_reg;
    assign dispatch_uop.src2_is_reg = dispatch_src2_is_reg;
    assign dispatch_uop.prs1        = dispatch_prs1;
    assign dispatch_uop.prs2        = dispatch_prs2;
    assign dispatch_uop.prd         = dispatch_prd;
    assign dispatch_uop.robid       = dispatch_robid;

    issue_dispatch_ctrl u_dispatch_ctrl (
        .clock         (clock),
        .reset_n       (reset_n),
        .dispatch_req  (dispatch_req),
        .dispatch_ack  (dispatch_ack),
        .dispatch_uop  (dispatch_uop),
        .slot_valid    (slot_valid),
        .src1_pending  (src1_pending),
        .src2_pending  (src2_pending),
        .dispatch_fire (dispatch_fire),
        .dispatch      (dispatch_bus.ctrl)
    );

    issue_wakeup u_wakeup (
        .clock           (clock),
        .reset_n         (reset_n),
        .flush           (flush),
        .writeback_valid (writeback_valid),
        .writeback_preg  (writeback_preg),
        .dispatch_uop    (dispatch_uop),
        .dispatch_fire   (dispatch_fire),
        .slot_prs1       (slot_prs1),
        .slot_prs2       (slot_prs2),
        .slot_valid      (slot_valid),
        .src1_pending    (src1_pending),
        .src2_pending    (src2_pending),
        .wakeup_src1     (wakeup_src1),
        .wakeup_src2     (wakeup_src2)
    );

    for (genvar i = 0; i < `ISSUE_DEPTH; i++) begin : g_slot
        issue_queue_entry #(
            .SLOT (i)
        ) u_entry (
            .clock       (clock),
            .reset_n     (reset_n),
            .dispatch    (dispatch_bus.slot),
            .wakeup_src1 (wakeup_src1[i]),
            .wakeup_src2 (wakeup_src2[i]),
            .issuing     (issuing[i]),
            .flush       (flush),
            .valid       (slot_valid[i]),
            .ready_to_go (slot_ready[i]),
            .uop         (slot_uop[i])
        );

        assign slot_prs1[i] = slot_uop[i].prs1;
        assign slot_prs2[i] = slot_uop[i].prs2;
    end

    issue_select u_select (
        .clock       (clock),
        .reset_n     (reset_n),
        .slot_ready  (slot_ready),
        .slot_uop    (slot_uop),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .issuing     (issuing)
    );

    // Source type flags are consumed at dispatch only
    assign issue_pc     = issue_uop.pc;
    assign issue_imm    = issue_uop.imm;
    assign issue_alu_op = issue_uop.alu_op;
    assign issue_prs1   = issue_uop.prs1;
    assign issue_prs2   = issue_uop.prs2;
    assign issue_prd    = issue_uop.prd;
    assign issue_robid  = issue_uop.robid;
endmodule

//--- test/issue_queue_tb.sv
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_queue_tb;
    localparam int N_UOPS  = 251;
    localparam int TIMEOUT = 40 * N_UOPS + 200;
    localparam int PREGS   = 1 << `PREG_BITS;
    localparam int ROBS    = 1 << (`ROB_BITS + 1);

    logic                  clock = 1'b0;
    logic                  reset_n = 1'b0;
    logic                  flush = 1'b0;
    logic                  dispatch_req = 1'b0;
    logic                  dispatch_ack;
    issue_pkg::issue_uop_t drv = '0;
    logic                  writeback_valid = 1'b0;
    logic [`PREG_BITS-1:0] writeback_preg = '0;
    logic                  issue_ready = 1'b0;
    logic                  issue_valid;
    logic [`PC_BITS-1:0]   issue_pc;
    logic [63:0]           issue_imm;
    issue_pkg::alu_op_t    issue_alu_op;
    logic [`PREG_BITS-1:0] issue_prs1;
    logic [`PREG_BITS-1:0] issue_prs2;
    logic [`PREG_BITS-1:0] issue_prd;
    logic [`ROB_BITS:0]    issue_robid;

    // Reference model state
    issue_pkg::issue_uop_t   uop_tab [ROBS];
    logic [ROBS-1:0]         wait1 = '0;
    logic [ROBS-1:0]         wait2 = '0;
    logic [`ROB_BITS:0]      slot_robid [`ISSUE_DEPTH];
    logic [`ISSUE_DEPTH-1:0] slot_live = '0;
    logic [PREGS-1:0]        ref_busy = '0;
    logic                    ack_model = 1'b0;
    logic [PREGS-1:0]        busy_snap = '0;
    logic                    live_snap = 1'b0;
    logic                    stalled = 1'b0;
    int                      stalled_slot = -1;
    issue_pkg::issue_uop_t   stalled_uop = '0;
    int                      cycles = 0;
    int                      dispatched = 0;
    int                      issued = 0;
    int                      flushed = 0;

    // Ready mode selects low (0) or high (1) or random (2)
    logic [1:0]            ready_mode = 2'd0;
    logic                  wb_mode = 1'b0;
    logic [31:0]           rng_stim = 32'h5402;
    logic [31:0]           rng_bg = ~32'h5402;
    logic [`ROB_BITS:0]    next_robid = '0;
    logic [`PREG_BITS-1:0] last_prd = '0;
    string                 test_name = "reset";

    issue_queue u_issue_queue (
        .clock                (clock),
        .reset_n              (reset_n),
        .flush                (flush),
        .dispatch_req         (dispatch_req),
        .dispatch_ack         (dispatch_ack),
        .dispatch_pc          (drv.pc),
        .dispatch_imm         (drv.imm),
        .dispatch_alu_op      (drv.alu_op),
        .dispatch_src1_is_reg (drv.src1_is_reg),
        .dispatch_src2_is_reg (drv.src2_is_reg),
        .dispatch_prs1        (drv.prs1),
        .dispatch_prs2        (drv.prs2),
        .dispatch_prd         (drv.prd),
        .dispatch_robid       (drv.robid),
        .writeback_valid      (writeback_valid),
        .writeback_preg       (writeback_preg),
        .issue_ready          (issue_ready),
        .issue_valid          (issue_valid),
        .issue_pc             (issue_pc),
        .issue_imm            (issue_imm),
        .issue_alu_op         (issue_alu_op),
        .issue_prs1           (issue_prs1),
        .issue_prs2           (issue_prs2),
        .issue_prd            (issue_prd),
        .issue_robid          (issue_robid)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_stim = xorshift(rng_stim);
        return rng_stim;
    endfunction

    function automatic issue_pkg::issue_uop_t expected_uop(input logic [`ROB_BITS:0] robid);
        return uop_tab[robid];
    endfunction

    function automatic logic may_issue(input logic [`ROB_BITS:0] robid);
        return !wait1[robid] && !wait2[robid];
    endfunction

    function automatic int grant_slot();
        for (int i = 0; i < `ISSUE_DEPTH; i++) begin
            if (slot_live[i] && may_issue(slot_robid[i])) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int alloc_slot();
        for (int i = 0; i < `ISSUE_DEPTH; i++) begin
            if (!slot_live[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // The issue port carries no source type flags
    function automatic issue_pkg::issue_uop_t visible(input issue_pkg::issue_uop_t u);
        u.src1_is_reg = 1'b0;
        u.src2_is_reg = 1'b0;
        return u;
    endfunction

    function automatic issue_pkg::issue_uop_t observed_uop();
        issue_pkg::issue_uop_t u;
        u = '0;
        u.pc = issue_pc;
        u.imm = issue_imm;
        u.alu_op = issue_alu_op;
        u.prs1 = issue_prs1;
        u.prs2 = issue_prs2;
        u.prd = issue_prd;
        u.robid = issue_robid;
        return u;
    endfunction

    function automatic logic [`PREG_BITS-1:0] free_preg();
        logic [31:0]           r;
        logic [`PREG_BITS-1:0] p;
        r = next_rand();
        p = r[`PREG_BITS-1:0];
        for (int i = 0; i < PREGS; i++) begin
            if (p != '0 && !busy_snap[p]) begin
                return p;
            end
            p = p + 1'b1;
        end
        return '0;
    endfunction

    function automatic issue_pkg::issue_uop_t random_uop();
        issue_pkg::issue_uop_t u;
        logic [31:0]           r;
        u.pc = next_rand();
        u.imm = {next_rand(), next_rand()};
        r = next_rand();
        u.alu_op = issue_pkg::alu_op_t'(r[3:0] % 4'd10);
        u.src1_is_reg = r[4];
        u.src2_is_reg = r[5];
        u.prs1 = r[18] ? last_prd : r[11:6];
        u.prs2 = r[19] ? last_prd : r[17:12];
        u.prd = free_preg();
        u.robid = next_robid;
        last_prd = u.prd;
        next_robid = next_robid + 1'b1;
        return u;
    endfunction

    // Sources on x0 never wait
    function automatic issue_pkg::issue_uop_t ready_uop();
        issue_pkg::issue_uop_t u;
        u = random_uop();
        u.prs1 = '0;
        u.prs2 = '0;
        return u;
    endfunction

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_uop(input string what, input issue_pkg::issue_uop_t exp,
                             input issue_pkg::issue_uop_t act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic start_dispatch(input issue_pkg::issue_uop_t u);
        @(posedge clock);
        drv <= u;
        dispatch_req <= 1'b1;
    endtask

    task automatic finish_dispatch();
        @(posedge clock);
        while (!dispatch_ack) @(posedge clock);
        dispatch_req <= 1'b0;
        @(posedge clock);
        while (dispatch_ack) @(posedge clock);
    endtask

    task automatic dispatch(input issue_pkg::issue_uop_t u);
        start_dispatch(u);
        finish_dispatch();
    endtask

    task automatic wait_drained();
        @(posedge clock);
        while (live_snap || dispatch_ack) @(posedge clock);
    endtask

    // Compare against the model, then advance it with the values seen at this edge
    always @(posedge clock) begin
        int                    g;
        int                    a;
        logic                  fire;
        issue_pkg::issue_uop_t seen;
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout: no end of run after %0d cycles", cycles);
            stop_with_failure();
        end
        if (reset_n) begin
            g = grant_slot();
            a = alloc_slot();
            fire = dispatch_req && !ack_model && (a >= 0);
            seen = observed_uop();
            check_bit("dispatch_ack", ack_model, dispatch_ack);
            if (stalled) begin
                check_bit("valid held under back-pressure", 1'b1, issue_valid);
            end
            if (stalled && g == stalled_slot) begin
                check_uop("fields held under back-pressure", stalled_uop, seen);
            end
            check_bit("issue_valid", g >= 0, issue_valid);
            if (g >= 0) begin
                check_uop("issue fields", visible(expected_uop(slot_robid[g])), seen);
            end
            stalled = (g >= 0) && !issue_ready && !flush;
            stalled_slot = g;
            if (g >= 0) begin
                stalled_uop = visible(expected_uop(slot_robid[g]));
            end
            if (g >= 0 && issue_ready) begin
                slot_live[g] = 1'b0;
                issued++;
            end
            if (writeback_valid) begin
                ref_busy[writeback_preg] = 1'b0;
                for (int i = 0; i < `ISSUE_DEPTH; i++) begin
                    if (slot_live[i] && uop_tab[slot_robid[i]].prs1 == writeback_preg) begin
                        wait1[slot_robid[i]] = 1'b0;
                    end
                    if (slot_live[i] && uop_tab[slot_robid[i]].prs2 == writeback_preg) begin
                        wait2[slot_robid[i]] = 1'b0;
                    end
                end
            end
            if (fire) begin
                slot_live[a] = 1'b1;
                slot_robid[a] = drv.robid;
                uop_tab[drv.robid] = drv;
                wait1[drv.robid] = drv.src1_is_reg && ref_busy[drv.prs1];
                wait2[drv.robid] = drv.src2_is_reg && ref_busy[drv.prs2];
                if (drv.prd != '0) begin
                    ref_busy[drv.prd] = 1'b1;
                end
                dispatched++;
            end
            if (flush) begin
                flushed += $countones(slot_live);
                slot_live = '0;
                ref_busy = '0;
            end
            ack_model = fire || (dispatch_req && ack_model);
        end
        busy_snap <= ref_busy;
        live_snap <= |slot_live;
    end

    // Background issue_ready and writeback traffic
    always @(posedge clock) begin
        logic [`PREG_BITS-1:0] p;
        logic                  found;
        rng_bg = xorshift(rng_bg);
        issue_ready <= (ready_mode == 2'd2) ? rng_bg[0] : ready_mode[0];
        if (wb_mode) begin
            p = rng_bg[13:8];
            found = 1'b0;
            for (int i = 0; i < PREGS; i++) begin
                if (!found && busy_snap[p]) begin
                    found = 1'b1;
                end else if (!found) begin
                    p = p + 1'b1;
                end
            end
            writeback_valid <= found && (rng_bg[2:1] != 2'b00);
            writeback_preg <= p;
        end
    end

    initial begin
        issue_pkg::issue_uop_t u;
        issue_pkg::issue_uop_t p;
        issue_pkg::issue_uop_t q;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        test_name = "handshake";
        repeat (8) dispatch(ready_uop());
        start_dispatch(ready_uop());
        repeat (4) @(posedge clock);
        check_bit("ack while queue full", 1'b0, dispatch_ack);
        ready_mode <= 2'd1;
        finish_dispatch();
        wait_drained();

        test_name = "ready issue";
        repeat (4) dispatch(ready_uop());
        wait_drained();

        test_name = "wakeup";
        p = ready_uop();
        dispatch(p);
        u = random_uop();
        u.src1_is_reg = 1'b1;
        u.prs1 = p.prd;
        u.src2_is_reg = 1'b0;
        dispatch(u);
        repeat (5) @(posedge clock);
        check_bit("consumer before writeback", 1'b0, issue_valid);
        writeback_valid <= 1'b1;
        writeback_preg <= p.prd;
        @(posedge clock);
        writeback_valid <= 1'b0;
        wait_drained();
        // Writeback lands in the same cycle as the dispatch write
        q = ready_uop();
        dispatch(q);
        u = random_uop();
        u.src1_is_reg = 1'b1;
        u.prs1 = q.prd;
        u.src2_is_reg = 1'b0;
        start_dispatch(u);
        writeback_valid <= 1'b1;
        writeback_preg <= q.prd;
        @(posedge clock);
        writeback_valid <= 1'b0;
        finish_dispatch();
        wait_drained();

        test_name = "flush";
        ready_mode <= 2'd0;
        p = ready_uop();
        dispatch(p);
        q = ready_uop();
        dispatch(q);
        u = random_uop();
        u.src1_is_reg = 1'b1;
        u.prs1 = p.prd;
        dispatch(u);
        @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        ready_mode <= 2'd1;
        repeat (4) @(posedge clock);
        check_bit("issue after flush", 1'b0, issue_valid);
        u = random_uop();
        u.src1_is_reg = 1'b1;
        u.prs1 = p.prd;
        u.src2_is_reg = 1'b1;
        u.prs2 = q.prd;
        dispatch(u);
        wait_drained();

        test_name = "back-pressure";
        ready_mode <= 2'd2;
        wb_mode <= 1'b1;
        repeat (30) dispatch(random_uop());
        wait_drained();

        test_name = "random mix";
        repeat (200) dispatch(random_uop());
        wait_drained();

        @(negedge clock);
        if (live_snap || issued + flushed != dispatched) begin
            $display("Micro-ops unaccounted for: %0d dispatched, %0d issued, %0d flushed",
                     dispatched, issued, flushed);
            stop_with_failure();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end
endmodule

//--- verilog.f
+incdir+include
source/issue_pkg.sv
source/issue_dispatch_if.sv
source/issue_queue_entry.sv
source/issue_wakeup.sv
source/issue_dispatch_ctrl.sv
source/issue_select.sv
source/issue_queue.sv
test/issue_queue_tb.sv

//--- Makefile
TB := issue_queue_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module issue_queue

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TB) -o $(TB)_sim
	-./obj_dir/$(TB)_sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
